// ==== common/rv_pkg.sv ====
// rv64i decode package
// widths, opcode groups, type bit positions and operation codes
package rv_pkg;

  localparam int xlen       = 64;
  localparam int inst_w     = 32;
  localparam int reg_addr_w = 5;
  localparam int reg_num    = 32;

  // opcode bits 6:2
  localparam logic [4:0] opgrp_sys      = 5'b11100;
  localparam logic [4:0] opgrp_regreg_w = 5'b01110;
  localparam logic [4:0] opgrp_regimm_w = 5'b00110;
  localparam logic [4:0] opgrp_regimm   = 5'b00100;
  localparam logic [4:0] opgrp_regreg   = 5'b01100;
  localparam logic [4:0] opgrp_branch   = 5'b11000;
  localparam logic [4:0] opgrp_load     = 5'b00000;
  localparam logic [4:0] opgrp_store    = 5'b01000;
  localparam logic [4:0] opgrp_lui      = 5'b01101;
  localparam logic [4:0] opgrp_auipc    = 5'b00101;
  localparam logic [4:0] opgrp_jal      = 5'b11011;
  localparam logic [4:0] opgrp_jalr     = 5'b11001;

  // bit positions in the one-hot inst_type
  localparam int ty_sys      = 7;
  localparam int ty_regreg_w = 6;
  localparam int ty_regimm_w = 5;
  localparam int ty_regimm   = 4;
  localparam int ty_regreg   = 3;
  localparam int ty_branch   = 2;
  localparam int ty_load     = 1;
  localparam int ty_store    = 0;

  // operation codes, numbered from 0 in this order
  typedef enum logic [7:0] {
    op_nop, op_add, op_sub, op_sll, op_slt, op_sltu, op_xor, op_srl, op_sra, op_or, op_and,
    op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi, op_slli, op_srli, op_srai,
    op_addw, op_subw, op_sllw, op_srlw, op_sraw,
    op_addiw, op_slliw, op_srliw, op_sraiw,
    op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
    op_lui, op_auipc, op_jal, op_jalr, op_load, op_store,
    op_csrrw, op_csrrs, op_csrrc, op_csrrwi, op_csrrsi, op_csrrci
  } op_e;

endpackage

// ==== rtl/regfile.sv ====
// integer register file, 32 x 64 bit
// two combinational read ports with write-through, one synchronous write port
`timescale 1ns/10ps

module regfile
  import rv_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic [reg_addr_w-1:0] ra1_i,
  input  logic [reg_addr_w-1:0] ra2_i,
  input  logic                  we_i,
  input  logic [reg_addr_w-1:0] wa_i,
  input  logic [xlen-1:0]       wd_i,
  output logic [xlen-1:0]       rd1_o,
  output logic [xlen-1:0]       rd2_o
);

  logic [xlen-1:0] regs [reg_num];
  logic            wr_live;

  // x0 writes dropped so regs[0] stays zero
  assign wr_live = we_i && (wa_i != '0);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < reg_num; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[wa_i] <= wd_i;
    end
  end

  // same-cycle writeback visible to decode
  assign rd1_o = (wr_live && (wa_i == ra1_i)) ? wd_i : regs[ra1_i];
  assign rd2_o = (wr_live && (wa_i == ra2_i)) ? wd_i : regs[ra2_i];

endmodule

// ==== rtl/if_id_reg.sv ====
// fetch to decode pipeline register
// flush drops the entry, hold keeps it for a stall
`timescale 1ns/10ps

module if_id_reg
  import rv_pkg::*;
(
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              hold_i,
  input  logic              flush_i,
  input  logic              valid_i,
  input  logic [inst_w-1:0] inst_i,
  input  logic [xlen-1:0]   pc_i,
  output logic              valid_o,
  output logic [inst_w-1:0] inst_o,
  output logic [xlen-1:0]   pc_o
);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o <= 1'b0;
    end else if (flush_i) begin
      valid_o <= 1'b0;
    end else if (!hold_i) begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!hold_i) begin
      inst_o <= inst_i;
      pc_o   <= pc_i;
    end
  end

  // a stalled jalr must keep its slot, not be flushed
  a_hold_flush: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_o |-> !(hold_i && flush_i));

endmodule

// ==== rtl/id_ex_reg.sv ====
// decode to execute pipeline register
// a bubble writes an empty slot so a stalled instruction reaches ex once
`timescale 1ns/10ps

module id_ex_reg
  import rv_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  bubble_i,
  input  logic                  valid_i,
  input  logic [7:0]            inst_type_i,
  input  logic [7:0]            op_i,
  input  logic [xlen-1:0]       op1_i,
  input  logic [xlen-1:0]       op2_i,
  input  logic                  rd_ena_i,
  input  logic [reg_addr_w-1:0] rd_addr_i,
  input  logic [11:0]           mem_off_i,
  input  logic [2:0]            funct3_i,
  input  logic [xlen-1:0]       pc_i,
  output logic                  ex_valid_o,
  output logic [7:0]            ex_inst_type_o,
  output logic [7:0]            ex_op_o,
  output logic [xlen-1:0]       ex_op1_o,
  output logic [xlen-1:0]       ex_op2_o,
  output logic                  ex_rd_ena_o,
  output logic [reg_addr_w-1:0] ex_rd_addr_o,
  output logic [11:0]           ex_mem_off_o,
  output logic [2:0]            ex_funct3_o,
  output logic [xlen-1:0]       ex_pc_o
);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ex_valid_o  <= 1'b0;
      ex_rd_ena_o <= 1'b0;
    end else if (bubble_i) begin
      ex_valid_o  <= 1'b0;
      ex_rd_ena_o <= 1'b0;
    end else begin
      ex_valid_o  <= valid_i;
      ex_rd_ena_o <= rd_ena_i;
    end
  end

  always_ff @(posedge clk_i) begin
    ex_inst_type_o <= inst_type_i;
    ex_op_o        <= op_i;
    ex_op1_o       <= op1_i;
    ex_op2_o       <= op2_i;
    ex_rd_addr_o   <= rd_addr_i;
    ex_mem_off_o   <= mem_off_i;
    ex_funct3_o    <= funct3_i;
    ex_pc_o        <= pc_i;
  end

  // decoder only enables rd for a live instruction
  a_rd_needs_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ex_rd_ena_o |-> ex_valid_o);

endmodule

// ==== rtl/pipe_ctrl.sv ====
// decode stage hazard control
// turns load-use stall and jalr redirect into hold, bubble, flush and ready
`timescale 1ns/10ps

module pipe_ctrl (
  input  logic id_valid_i,
  input  logic stall_req_i,
  input  logic jalr_i,
  output logic if_id_hold_o,
  output logic if_id_flush_o,
  output logic id_ex_bubble_o,
  output logic fetch_ready_o,
  output logic redirect_o
);

  logic stall;

  always_comb begin
    stall          = id_valid_i && stall_req_i;
    if_id_hold_o   = stall;
    id_ex_bubble_o = stall;
    fetch_ready_o  = !stall;
    // jalr waits until its rs1 is no longer a pending load
    redirect_o     = id_valid_i && jalr_i && !stall;
    if_id_flush_o  = redirect_o;
  end

endmodule

// ==== decode/id_decoder.sv ====
// rv64i instruction decoder
// classifies the instruction, builds forwarded operands, flags load-use and jalr
`timescale 1ns/10ps

module id_decoder
  import rv_pkg::*;
(
  input  logic                  valid_i,
  input  logic [inst_w-1:0]     inst_i,
  input  logic [xlen-1:0]       pc_i,
  input  logic [xlen-1:0]       rs1_data_i,
  input  logic [xlen-1:0]       rs2_data_i,
  input  logic                  ex_rd_ena_i,
  input  logic [reg_addr_w-1:0] ex_rd_addr_i,
  input  logic [xlen-1:0]       ex_rd_data_i,
  input  logic                  ex_is_load_i,
  input  logic                  mem_rd_ena_i,
  input  logic [reg_addr_w-1:0] mem_rd_addr_i,
  input  logic [xlen-1:0]       mem_rd_data_i,
  output logic [reg_addr_w-1:0] rs1_addr_o,
  output logic [reg_addr_w-1:0] rs2_addr_o,
  output logic                  stall_req_o,
  output logic [7:0]            inst_type_o,
  output logic [7:0]            op_o,
  output logic [xlen-1:0]       op1_o,
  output logic [xlen-1:0]       op2_o,
  output logic                  rd_ena_o,
  output logic [reg_addr_w-1:0] rd_addr_o,
  output logic [11:0]           mem_off_o,
  output logic [2:0]            funct3_o,
  output logic                  jalr_o,
  output logic [xlen-1:0]       jalr_pc_o
);

  logic [4:0]            grp;
  logic [2:0]            funct3;
  logic                  f7_b5;
  logic [reg_addr_w-1:0] rs1, rs2, rd;
  logic [xlen-1:0]       imm_i, imm_u;
  logic [11:0]           imm_s;
  logic                  dec_en;
  logic [7:0]            ty;
  logic                  is_lui, is_auipc, is_jal, is_jalr;
  logic                  csr_rs1, csr_imm;
  logic                  rs1_rd, rs2_rd;
  logic                  ex_hit1, ex_hit2, mem_hit1, mem_hit2;
  logic [xlen-1:0]       src1, src2, jalr_sum;
  op_e                   op;

  assign grp    = inst_i[6:2];
  assign funct3 = inst_i[14:12];
  assign f7_b5  = inst_i[30];
  assign rs1    = inst_i[19:15];
  assign rs2    = inst_i[24:20];
  assign rd     = inst_i[11:7];
  assign imm_i  = {{(xlen-12){inst_i[31]}}, inst_i[31:20]};
  assign imm_s  = {inst_i[31:25], inst_i[11:7]};
  assign imm_u  = {{(xlen-32){inst_i[31]}}, inst_i[31:12], 12'b0};

  // only 32-bit encodings are decoded
  assign dec_en = valid_i && (inst_i[1:0] == 2'b11);

  always_comb begin
    ty              = '0;
    ty[ty_sys]      = dec_en && (grp == opgrp_sys);
    ty[ty_regreg_w] = dec_en && (grp == opgrp_regreg_w);
    ty[ty_regimm_w] = dec_en && (grp == opgrp_regimm_w);
    ty[ty_regimm]   = dec_en && (grp == opgrp_regimm);
    ty[ty_regreg]   = dec_en && (grp == opgrp_regreg);
    ty[ty_branch]   = dec_en && (grp == opgrp_branch);
    ty[ty_load]     = dec_en && (grp == opgrp_load);
    ty[ty_store]    = dec_en && (grp == opgrp_store);
  end

  assign is_lui   = dec_en && (grp == opgrp_lui);
  assign is_auipc = dec_en && (grp == opgrp_auipc);
  assign is_jal   = dec_en && (grp == opgrp_jal);
  assign is_jalr  = dec_en && (grp == opgrp_jalr);
  assign csr_rs1  = ty[ty_sys] && !funct3[2] && (funct3[1:0] != 2'b00);
  assign csr_imm  = ty[ty_sys] && funct3[2] && (funct3[1:0] != 2'b00);

  always_comb begin
    op = op_nop;
    if (dec_en) begin
      casez ({grp, f7_b5, funct3})
        {opgrp_regreg, 4'b0000}:   op = op_add;
        {opgrp_regreg, 4'b1000}:   op = op_sub;
        {opgrp_regreg, 4'b0001}:   op = op_sll;
        {opgrp_regreg, 4'b0010}:   op = op_slt;
        {opgrp_regreg, 4'b0011}:   op = op_sltu;
        {opgrp_regreg, 4'b0100}:   op = op_xor;
        {opgrp_regreg, 4'b0101}:   op = op_srl;
        {opgrp_regreg, 4'b1101}:   op = op_sra;
        {opgrp_regreg, 4'b0110}:   op = op_or;
        {opgrp_regreg, 4'b0111}:   op = op_and;
        {opgrp_regimm, 4'b?000}:   op = op_addi;
        {opgrp_regimm, 4'b?010}:   op = op_slti;
        {opgrp_regimm, 4'b?011}:   op = op_sltiu;
        {opgrp_regimm, 4'b?100}:   op = op_xori;
        {opgrp_regimm, 4'b?110}:   op = op_ori;
        {opgrp_regimm, 4'b?111}:   op = op_andi;
        {opgrp_regimm, 4'b0001}:   op = op_slli;
        {opgrp_regimm, 4'b0101}:   op = op_srli;
        {opgrp_regimm, 4'b1101}:   op = op_srai;
        {opgrp_regreg_w, 4'b0000}: op = op_addw;
        {opgrp_regreg_w, 4'b1000}: op = op_subw;
        {opgrp_regreg_w, 4'b0001}: op = op_sllw;
        {opgrp_regreg_w, 4'b0101}: op = op_srlw;
        {opgrp_regreg_w, 4'b1101}: op = op_sraw;
        {opgrp_regimm_w, 4'b?000}: op = op_addiw;
        {opgrp_regimm_w, 4'b0001}: op = op_slliw;
        {opgrp_regimm_w, 4'b0101}: op = op_srliw;
        {opgrp_regimm_w, 4'b1101}: op = op_sraiw;
        {opgrp_branch, 4'b?000}:   op = op_beq;
        {opgrp_branch, 4'b?001}:   op = op_bne;
        {opgrp_branch, 4'b?100}:   op = op_blt;
        {opgrp_branch, 4'b?101}:   op = op_bge;
        {opgrp_branch, 4'b?110}:   op = op_bltu;
        {opgrp_branch, 4'b?111}:   op = op_bgeu;
        {opgrp_lui, 4'b????}:      op = op_lui;
        {opgrp_auipc, 4'b????}:    op = op_auipc;
        {opgrp_jal, 4'b????}:      op = op_jal;
        {opgrp_jalr, 4'b?000}:     op = op_jalr;
        {opgrp_load, 4'b????}:     op = op_load;
        {opgrp_store, 4'b????}:    op = op_store;
        {opgrp_sys, 4'b?001}:      op = op_csrrw;
        {opgrp_sys, 4'b?010}:      op = op_csrrs;
        {opgrp_sys, 4'b?011}:      op = op_csrrc;
        {opgrp_sys, 4'b?101}:      op = op_csrrwi;
        {opgrp_sys, 4'b?110}:      op = op_csrrsi;
        {opgrp_sys, 4'b?111}:      op = op_csrrci;
        default:                   op = op_nop;
      endcase
    end
  end

  // every group below sys reads rs1
  assign rs1_rd     = (|ty[ty_regreg_w:ty_store]) || is_jalr || csr_rs1;
  assign rs2_rd     = ty[ty_regreg_w] || ty[ty_regreg] || ty[ty_branch] || ty[ty_store];
  assign rs1_addr_o = rs1_rd ? rs1 : '0;
  assign rs2_addr_o = rs2_rd ? rs2 : '0;

  // ex beats mem, x0 never matches
  assign ex_hit1  = ex_rd_ena_i && (ex_rd_addr_i == rs1_addr_o) && (rs1_addr_o != '0);
  assign ex_hit2  = ex_rd_ena_i && (ex_rd_addr_i == rs2_addr_o) && (rs2_addr_o != '0);
  assign mem_hit1 = mem_rd_ena_i && (mem_rd_addr_i == rs1_addr_o) && (rs1_addr_o != '0);
  assign mem_hit2 = mem_rd_ena_i && (mem_rd_addr_i == rs2_addr_o) && (rs2_addr_o != '0);
  assign src1 = ex_hit1 ? ex_rd_data_i : (mem_hit1 ? mem_rd_data_i : rs1_data_i);
  assign src2 = ex_hit2 ? ex_rd_data_i : (mem_hit2 ? mem_rd_data_i : rs2_data_i);

  // load in ex cannot forward yet
  assign stall_req_o = ex_is_load_i && (ex_rd_addr_i != '0) &&
                       ((ex_rd_addr_i == rs1_addr_o) || (ex_rd_addr_i == rs2_addr_o));

  assign op1_o = rs1_rd               ? src1 :
                 (is_auipc || is_jal) ? pc_i :
                 csr_imm              ? {{(xlen-reg_addr_w){1'b0}}, rs1} : '0;
  assign op2_o = rs2_rd                                                ? src2  :
                 (ty[ty_regimm] || ty[ty_regimm_w] || ty[ty_sys])      ? imm_i :
                 (is_lui || is_auipc)                                  ? imm_u :
                 (is_jal || is_jalr)                                   ? pc_i  : '0;

  assign rd_ena_o  = (rd != '0) && (ty[ty_sys] || ty[ty_regreg_w] || ty[ty_regimm_w] ||
                     ty[ty_regimm] || ty[ty_regreg] || ty[ty_load] ||
                     is_lui || is_auipc || is_jal || is_jalr);
  assign rd_addr_o = rd_ena_o ? rd : '0;
  assign mem_off_o = ty[ty_load] ? imm_i[11:0] : (ty[ty_store] ? imm_s : '0);
  assign funct3_o  = dec_en ? funct3 : '0;

  assign inst_type_o = ty;
  assign op_o        = op;

  assign jalr_sum  = src1 + imm_i;
  assign jalr_o    = is_jalr;
  assign jalr_pc_o = is_jalr ? {jalr_sum[xlen-1:1], 1'b0} : '0;

  always_comb begin
    a_type_onehot: assert ($onehot0(inst_type_o));
  end

endmodule

// ==== rtl/decode_stage_top.sv ====
// rv64i decode stage
// if/id register, decoder, register file, hazard control and id/ex register
`timescale 1ns/10ps

module decode_stage_top
  import rv_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  inst_valid_i,
  input  logic [inst_w-1:0]     inst_i,
  input  logic [xlen-1:0]       pc_i,
  output logic                  fetch_ready_o,
  output logic                  redirect_o,
  output logic [xlen-1:0]       redirect_pc_o,
  input  logic                  ex_rd_ena_i,
  input  logic [reg_addr_w-1:0] ex_rd_addr_i,
  input  logic [xlen-1:0]       ex_rd_data_i,
  input  logic                  ex_is_load_i,
  input  logic                  mem_rd_ena_i,
  input  logic [reg_addr_w-1:0] mem_rd_addr_i,
  input  logic [xlen-1:0]       mem_rd_data_i,
  input  logic                  wb_ena_i,
  input  logic [reg_addr_w-1:0] wb_addr_i,
  input  logic [xlen-1:0]       wb_data_i,
  output logic                  ex_valid_o,
  output logic [7:0]            ex_inst_type_o,
  output logic [7:0]            ex_op_o,
  output logic [xlen-1:0]       ex_op1_o,
  output logic [xlen-1:0]       ex_op2_o,
  output logic                  ex_rd_ena_o,
  output logic [reg_addr_w-1:0] ex_rd_addr_o,
  output logic [11:0]           ex_mem_off_o,
  output logic [2:0]            ex_funct3_o,
  output logic [xlen-1:0]       ex_pc_o
);

  logic                  id_valid, id_hold, id_flush, id_bubble, stall_req, jalr;
  logic [inst_w-1:0]     id_inst;
  logic [xlen-1:0]       id_pc, rs1_data, rs2_data, op1, op2;
  logic [reg_addr_w-1:0] rs1_addr, rs2_addr, rd_addr;
  logic [7:0]            inst_type, op;
  logic                  rd_ena;
  logic [11:0]           mem_off;
  logic [2:0]            funct3;

  if_id_reg u_if_id (
    .clk_i, .arst_n_i, .hold_i(id_hold), .flush_i(id_flush),
    .valid_i(inst_valid_i), .inst_i, .pc_i,
    .valid_o(id_valid), .inst_o(id_inst), .pc_o(id_pc)
  );

  id_decoder u_dec (
    .valid_i(id_valid), .inst_i(id_inst), .pc_i(id_pc),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .ex_rd_ena_i, .ex_rd_addr_i, .ex_rd_data_i, .ex_is_load_i,
    .mem_rd_ena_i, .mem_rd_addr_i, .mem_rd_data_i,
    .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr), .stall_req_o(stall_req),
    .inst_type_o(inst_type), .op_o(op), .op1_o(op1), .op2_o(op2),
    .rd_ena_o(rd_ena), .rd_addr_o(rd_addr), .mem_off_o(mem_off), .funct3_o(funct3),
    .jalr_o(jalr), .jalr_pc_o(redirect_pc_o)
  );

  regfile u_rf (
    .clk_i, .arst_n_i, .ra1_i(rs1_addr), .ra2_i(rs2_addr),
    .we_i(wb_ena_i), .wa_i(wb_addr_i), .wd_i(wb_data_i),
    .rd1_o(rs1_data), .rd2_o(rs2_data)
  );

  pipe_ctrl u_ctrl (
    .id_valid_i(id_valid), .stall_req_i(stall_req), .jalr_i(jalr),
    .if_id_hold_o(id_hold), .if_id_flush_o(id_flush), .id_ex_bubble_o(id_bubble),
    .fetch_ready_o, .redirect_o
  );

  id_ex_reg u_id_ex (
    .clk_i, .arst_n_i, .bubble_i(id_bubble), .valid_i(id_valid),
    .inst_type_i(inst_type), .op_i(op), .op1_i(op1), .op2_i(op2),
    .rd_ena_i(rd_ena), .rd_addr_i(rd_addr), .mem_off_i(mem_off), .funct3_i(funct3),
    .pc_i(id_pc),
    .ex_valid_o, .ex_inst_type_o, .ex_op_o, .ex_op1_o, .ex_op2_o,
    .ex_rd_ena_o, .ex_rd_addr_o, .ex_mem_off_o, .ex_funct3_o, .ex_pc_o
  );

endmodule

// ==== tb/decode_tb.sv ====
// testbench for the rv64i decode stage
// drives cases from a data file and checks the ex outputs through a scoreboard
`timescale 1ns/10ps

module decode_tb
  import rv_pkg::*;
();

  localparam int n_fields = 20;
  localparam int max_cases = 32;

  logic                  clk_i, arst_n_i;
  logic                  inst_valid_i;
  logic [inst_w-1:0]     inst_i;
  logic [xlen-1:0]       pc_i;
  logic                  fetch_ready_o, redirect_o;
  logic [xlen-1:0]       redirect_pc_o;
  logic                  ex_rd_ena_i, ex_is_load_i, mem_rd_ena_i, wb_ena_i;
  logic [reg_addr_w-1:0] ex_rd_addr_i, mem_rd_addr_i, wb_addr_i;
  logic [xlen-1:0]       ex_rd_data_i, mem_rd_data_i, wb_data_i;
  logic                  ex_valid_o, ex_rd_ena_o;
  logic [7:0]            ex_inst_type_o, ex_op_o;
  logic [xlen-1:0]       ex_op1_o, ex_op2_o, ex_pc_o;
  logic [reg_addr_w-1:0] ex_rd_addr_o;
  logic [11:0]           ex_mem_off_o;
  logic [2:0]            ex_funct3_o;

  logic [63:0] case_mem [0:n_fields*max_cases];
  int          n_cases;
  int          errors;
  int          cycles;
  int          cycle_limit;
  int          sb_q[$];

  decode_stage_top dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [63:0] fld(input int idx, input int k);
    return case_mem[1 + idx*n_fields + k];
  endfunction

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("ERR t=%0t %s expected=%h actual=%h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic set_side(input int idx, input bit load_phase);
    logic [63:0] ex_ena;
    logic [63:0] ex_addr;
    logic [63:0] mem_ena;
    logic [63:0] mem_addr;
    logic [63:0] wb_ena;
    logic [63:0] wb_addr;
    ex_ena   = fld(idx, 3);
    ex_addr  = fld(idx, 4);
    mem_ena  = fld(idx, 6);
    mem_addr = fld(idx, 7);
    wb_ena   = fld(idx, 9);
    wb_addr  = fld(idx, 10);
    ex_rd_ena_i   <= load_phase | ex_ena[0];
    ex_rd_addr_i  <= ex_addr[4:0];
    ex_rd_data_i  <= load_phase ? 64'd0 : fld(idx, 5);
    ex_is_load_i  <= load_phase;
    mem_rd_ena_i  <= mem_ena[0];
    mem_rd_addr_i <= mem_addr[4:0];
    mem_rd_data_i <= fld(idx, 8);
    wb_ena_i      <= wb_ena[0];
    wb_addr_i     <= wb_addr[4:0];
    wb_data_i     <= fld(idx, 11);
  endtask

  task automatic clear_side();
    ex_rd_ena_i  <= 1'b0;
    ex_is_load_i <= 1'b0;
    mem_rd_ena_i <= 1'b0;
    wb_ena_i     <= 1'b0;
  endtask

  task automatic run_case(input int idx);
    logic [63:0] inst;
    logic [63:0] rpc;
    int          stall;
    inst  = fld(idx, 0);
    rpc   = fld(idx, 19);
    stall = int'(fld(idx, 2));
    repeat ($urandom % 2) @(posedge clk_i);
    @(posedge clk_i);
    inst_valid_i <= 1'b1;
    inst_i       <= inst[31:0];
    pc_i         <= fld(idx, 1);
    @(negedge clk_i);
    check("fetch_ready_o", 64'd1, 64'(fetch_ready_o));
    @(posedge clk_i);
    sb_q.push_back(idx);
    set_side(idx, stall > 0);
    // a jalr sees a younger instruction offered behind it
    inst_valid_i <= (rpc != 64'd0);
    inst_i       <= 32'h0000_0013;
    pc_i         <= 64'hdead_0000;
    for (int s = 0; s < stall; s++) begin
      @(negedge clk_i);
      check("fetch_ready_o", 64'd0, 64'(fetch_ready_o));
      check("redirect_o", 64'd0, 64'(redirect_o));
      @(posedge clk_i);
      if (s == stall - 1) set_side(idx, 1'b0);
    end
    @(negedge clk_i);
    check("fetch_ready_o", 64'd1, 64'(fetch_ready_o));
    check("redirect_o", 64'(rpc != 64'd0), 64'(redirect_o));
    check("redirect_pc_o", rpc, redirect_pc_o);
    @(posedge clk_i);
    clear_side();
    inst_valid_i <= 1'b0;
  endtask

  // scoreboard on the ex side
  always @(negedge clk_i) begin
    int          idx;
    logic [63:0] inst;
    if (arst_n_i && ex_valid_o) begin
      if (sb_q.size() == 0) begin
        $display("unexpected instruction on the ex outputs at t=%0t", $time);
        errors++;
      end else begin
        idx  = sb_q.pop_front();
        inst = fld(idx, 0);
        check("ex_inst_type_o", fld(idx, 12), 64'(ex_inst_type_o));
        check("ex_op_o", fld(idx, 13), 64'(ex_op_o));
        check("ex_op1_o", fld(idx, 14), ex_op1_o);
        check("ex_op2_o", fld(idx, 15), ex_op2_o);
        check("ex_rd_ena_o", fld(idx, 16), 64'(ex_rd_ena_o));
        check("ex_rd_addr_o", fld(idx, 17), 64'(ex_rd_addr_o));
        check("ex_mem_off_o", fld(idx, 18), 64'(ex_mem_off_o));
        check("ex_funct3_o", 64'(inst[14:12]), 64'(ex_funct3_o));
        check("ex_pc_o", fld(idx, 1), ex_pc_o);
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("run stopped after %0d cycles without finishing the cases", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    errors       = 0;
    cycles       = 0;
    cycle_limit  = 0;
    arst_n_i     = 1'b0;
    inst_valid_i = 1'b0;
    inst_i       = '0;
    pc_i         = '0;
    ex_rd_ena_i  = 1'b0;
    ex_rd_addr_i = '0;
    ex_rd_data_i = '0;
    ex_is_load_i = 1'b0;
    mem_rd_ena_i = 1'b0;
    mem_rd_addr_i = '0;
    mem_rd_data_i = '0;
    wb_ena_i     = 1'b0;
    wb_addr_i    = '0;
    wb_data_i    = '0;
    void'($urandom(32'h50b4));
    $readmemh("tb/decode_cases.txt", case_mem);
    n_cases     = int'(case_mem[0]);
    cycle_limit = 16 + 4*n_cases + 50;
    repeat (16) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    check("ex_valid_o", 64'd0, 64'(ex_valid_o));
    check("redirect_o", 64'd0, 64'(redirect_o));
    check("fetch_ready_o", 64'd1, 64'(fetch_ready_o));
    for (int i = 0; i < n_cases; i++) begin
      run_case(i);
    end
    repeat (2) @(negedge clk_i);
    if (sb_q.size() != 0) begin
      $display("%0d accepted instructions never reached the ex outputs", sb_q.size());
      errors++;
    end
    $display("cases %0d, errors %0d", n_cases, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== tb/decode_cases.txt ====
// inst pc stall ex_ena ex_addr ex_data mem_ena mem_addr mem_data wb_ena wb_addr wb_data
//   type op op1 op2 rd_ena rd_addr mem_off redirect_pc (first word: number of cases)
13
002081B3 100 0 0 0 0 1 2 22 1 1 11 08 01 11 22 1 3 0 0
402082B3 104 0 1 1 E1 1 1 A1 0 0 0 08 02 E1 0 1 5 0 0
FFF08213 108 0 0 0 0 0 0 0 0 0 0 10 0B 11 FFFFFFFFFFFFFFFF 1 4 0 0
0050031B 10C 0 1 0 DEAD 0 0 0 1 0 BEEF 20 19 0 5 1 6 0 0
402083BB 110 0 0 0 0 0 0 0 1 2 2222 40 15 11 2222 1 7 0 0
80000437 114 0 0 0 0 0 0 0 0 0 0 00 23 0 FFFFFFFF80000000 1 8 0 0
12345497 1000 0 0 0 0 0 0 0 0 0 0 00 24 1000 12345000 1 9 0 0
008000EF 2000 0 0 0 0 0 0 0 0 0 0 00 25 2000 2000 1 1 0 0
00208863 118 0 0 0 0 0 0 0 0 0 0 04 1D 11 2222 0 0 0 0
0020E863 11C 0 0 0 0 0 0 0 0 0 0 04 21 11 2222 0 0 0 0
FF80B503 120 0 0 0 0 0 0 0 0 0 0 02 27 11 0 1 A FF8 0
0020B623 124 0 0 0 0 0 0 0 0 0 0 01 28 11 2222 0 0 C 0
FE20AE23 128 0 0 0 0 0 0 0 0 0 0 01 28 11 2222 0 0 FFC 0
300095F3 12C 0 0 0 0 0 0 0 0 0 0 80 29 11 300 1 B 0 0
3412E673 130 0 0 0 0 0 0 0 0 0 0 80 2D 5 341 1 C 0 0
001706B3 134 2 1 E 1414 0 0 0 0 0 0 08 01 1414 11 1 D 0 0
01008067 3000 0 0 0 0 1 1 4001 0 0 0 00 26 4001 3000 0 0 0 4010
003702E7 3100 1 1 E 8000 0 0 0 0 0 0 00 26 8000 3100 1 5 0 8002
4020D7B3 138 0 0 0 0 0 0 0 0 0 0 08 08 11 2222 1 F 0 0

// ==== decode_stage.f ====
common/rv_pkg.sv
rtl/regfile.sv
rtl/if_id_reg.sv
rtl/id_ex_reg.sv
rtl/pipe_ctrl.sv
decode/id_decoder.sv
rtl/decode_stage_top.sv
tb/decode_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= decode_tb
FLIST     ?= decode_stage.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
